/* rtl/vending_pkg.sv */
// vending machine shared definitions
package vending_pkg;

    typedef logic [6:0] credit_t; // 0 to 127

    typedef struct packed {
        logic nickel;
        logic dime;
        logic fifty;
    } coin_pulses_t;

    // priority order, coffee first
    typedef struct packed {
        logic coffee;
        logic coke;
        logic oolong;
        logic water;
    } product_sel_t;

    typedef logic [3:0] led_t; // coffee on bit 3

    typedef enum logic [2:0] {
        INSERT      = 3'd0,
        VEND_COFFEE = 3'd1,
        VEND_COKE   = 3'd2,
        VEND_OOLONG = 3'd3,
        VEND_WATER  = 3'd4,
        REFUND      = 3'd5
    } vend_state_t;

    localparam credit_t PRICE_COFFEE = 7'd80;
    localparam credit_t PRICE_COKE   = 7'd30;
    localparam credit_t PRICE_OOLONG = 7'd25;
    localparam credit_t PRICE_WATER  = 7'd20;

    localparam credit_t CREDIT_MAX = 7'd100;

    localparam credit_t COIN_NICKEL = 7'd5;
    localparam credit_t COIN_DIME   = 7'd10;
    localparam credit_t COIN_FIFTY  = 7'd50;

    localparam credit_t PAYOUT_STEP = 7'd5;

    // active low, segment a on bit 6 down to g on bit 0
    typedef logic [6:0] seg_t;

    localparam seg_t SEG_DIGIT [0:9] = '{
        7'b0000001, // 0
        7'b1001111, // 1
        7'b0010010, // 2
        7'b0000110, // 3
        7'b1001100, // 4
        7'b0100100, // 5
        7'b0100000, // 6
        7'b0001111, // 7
        7'b0000000, // 8
        7'b0000100  // 9
    };

endpackage

/* rtl/button_pulse.sv */
// button debounce and single pulse
`timescale 1ns/1ps

module button_pulse #(
    parameter int DEBOUNCE_LEN = 4
) (
    input  logic clk,
    input  logic rst,
    input  logic btn,
    output logic press
);

    logic [DEBOUNCE_LEN-1:0] samples;
    logic                    pressed;
    logic                    pressed_d;

    assign pressed = &samples; // all samples high

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            samples   <= '0;
            pressed_d <= 1'b0;
        end else begin
            samples   <= DEBOUNCE_LEN'({samples, btn}); // oldest sample drops off
            pressed_d <= pressed;
        end
    end

    // rising edge of the debounced level
    assign press = pressed & ~pressed_d;

endmodule

/* rtl/vend_fsm.sv */
// vending state machine
`timescale 1ns/1ps

module vend_fsm (
    input  logic                      clk,
    input  logic                      rst,
    input  vending_pkg::coin_pulses_t coins,
    input  vending_pkg::product_sel_t select,
    input  logic                      cancel,
    input  vending_pkg::credit_t      payout_left,
    input  logic                      payout_done,
    output logic                      payout_load,
    output vending_pkg::credit_t      payout_amount,
    output vending_pkg::credit_t      show_amount,
    output vending_pkg::led_t         leds
);

    vending_pkg::vend_state_t state;
    vending_pkg::vend_state_t buy_state;
    vending_pkg::credit_t     credit;
    vending_pkg::credit_t     price;
    vending_pkg::led_t        afford;
    logic                     buy_ok;
    logic [7:0]               coin_sum; // one spare bit before saturation

    assign afford = {credit >= vending_pkg::PRICE_COFFEE,
                     credit >= vending_pkg::PRICE_COKE,
                     credit >= vending_pkg::PRICE_OOLONG,
                     credit >= vending_pkg::PRICE_WATER};

    // highest priority affordable product
    always_comb begin
        buy_state = vending_pkg::INSERT;
        price     = '0;
        buy_ok    = 1'b0;
        if (select.coffee && afford[3]) begin
            buy_state = vending_pkg::VEND_COFFEE;
            price     = vending_pkg::PRICE_COFFEE;
            buy_ok    = 1'b1;
        end else if (select.coke && afford[2]) begin
            buy_state = vending_pkg::VEND_COKE;
            price     = vending_pkg::PRICE_COKE;
            buy_ok    = 1'b1;
        end else if (select.oolong && afford[1]) begin
            buy_state = vending_pkg::VEND_OOLONG;
            price     = vending_pkg::PRICE_OOLONG;
            buy_ok    = 1'b1;
        end else if (select.water && afford[0]) begin
            buy_state = vending_pkg::VEND_WATER;
            price     = vending_pkg::PRICE_WATER;
            buy_ok    = 1'b1;
        end
    end

    assign coin_sum = {1'b0, credit}
                    + (coins.nickel ? {1'b0, vending_pkg::COIN_NICKEL} : 8'd0)
                    + (coins.dime   ? {1'b0, vending_pkg::COIN_DIME}   : 8'd0)
                    + (coins.fifty  ? {1'b0, vending_pkg::COIN_FIFTY}  : 8'd0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= vending_pkg::INSERT;
            credit <= '0;
        end else begin
            case (state)
                vending_pkg::INSERT: begin
                    if (cancel) begin
                        state  <= vending_pkg::REFUND;
                        credit <= '0;
                    end else if (buy_ok) begin
                        state  <= buy_state;
                        credit <= '0;
                    end else if (coin_sum > {1'b0, vending_pkg::CREDIT_MAX}) begin
                        credit <= vending_pkg::CREDIT_MAX;
                    end else begin
                        credit <= coin_sum[6:0];
                    end
                end
                default: begin
                    if (payout_done) begin
                        state <= vending_pkg::INSERT;
                    end
                end
            endcase
        end
    end

    // dispenser load in the decision cycle
    assign payout_load   = (state == vending_pkg::INSERT) && (cancel || buy_ok);
    assign payout_amount = cancel ? credit : credit - price;

    assign show_amount = (state == vending_pkg::INSERT) ? credit : payout_left;

    always_comb begin
        case (state)
            vending_pkg::INSERT:      leds = afford;
            vending_pkg::VEND_COFFEE: leds = 4'b1000;
            vending_pkg::VEND_COKE:   leds = 4'b0100;
            vending_pkg::VEND_OOLONG: leds = 4'b0010;
            vending_pkg::VEND_WATER:  leds = 4'b0001;
            default:                  leds = 4'b0000; // refund
        endcase
    end

endmodule

/* rtl/change_dispenser.sv */
// change payout counter
`timescale 1ns/1ps

module change_dispenser #(
    parameter int TICK_CYCLES = 100000000
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 payout_load,
    input  vending_pkg::credit_t payout_amount,
    output vending_pkg::credit_t payout_left,
    output logic                 payout_done
);

    localparam int CNT_W = (TICK_CYCLES > 1) ? $clog2(TICK_CYCLES) : 1;

    logic [CNT_W-1:0] tick_cnt;
    logic             active;
    logic             tick;

    assign tick = (tick_cnt == CNT_W'(TICK_CYCLES - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            payout_left <= '0;
            active      <= 1'b0;
            tick_cnt    <= '0;
        end else if (payout_load) begin
            payout_left <= payout_amount;
            active      <= 1'b1;
            tick_cnt    <= '0;
        end else if (active) begin
            if (payout_left == '0) begin
                active <= 1'b0; // finished
            end else if (tick) begin
                tick_cnt <= '0;
                // floor at zero
                if (payout_left <= vending_pkg::PAYOUT_STEP)
                    payout_left <= '0;
                else
                    payout_left <= payout_left - vending_pkg::PAYOUT_STEP;
            end else begin
                tick_cnt <= tick_cnt + 1'b1;
            end
        end
    end

    assign payout_done = active && (payout_left == '0);

endmodule

/* rtl/seg_display.sv */
// seven segment display driver
`timescale 1ns/1ps

module seg_display #(
    parameter int REFRESH_BITS = 20
) (
    input  logic                 clk,
    input  logic                 rst,
    input  vending_pkg::credit_t amount,
    output logic [3:0]           digits,
    output vending_pkg::seg_t    segments
);

    logic [REFRESH_BITS-1:0] refresh_cnt;
    logic [1:0]              sel;
    logic [1:0]              used;
    logic [1:0]              idx;
    logic [3:0]              hundreds;
    logic [3:0]              tens;
    logic [3:0]              units;
    logic [3:0]              value;

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            refresh_cnt <= '0;
        else
            refresh_cnt <= refresh_cnt + 1'b1;
    end

    assign sel = refresh_cnt[REFRESH_BITS-1 -: 2];

    // decimal split
    assign hundreds = 4'(amount / 7'd100);
    assign tens     = 4'((amount / 7'd10) % 7'd10);
    assign units    = 4'(amount % 7'd10);

    always_comb begin
        if (amount >= 7'd100)
            used = 2'd3;
        else if (amount >= 7'd10)
            used = 2'd2;
        else
            used = 2'd1;
    end

    // leading digits blanked, so only used positions are scanned
    assign idx = (sel >= used) ? used - 2'd1 : sel;

    always_comb begin
        case (idx)
            2'd0:    value = units;
            2'd1:    value = tens;
            default: value = hundreds;
        endcase
    end

    assign digits   = ~(4'b0001 << idx);
    assign segments = vending_pkg::SEG_DIGIT[value];

endmodule

/* rtl/vending_top.sv */
// vending controller top level
`timescale 1ns/1ps

module vending_top #(
    parameter int DEBOUNCE_LEN = 4,
    parameter int TICK_CYCLES  = 100000000,
    parameter int REFRESH_BITS = 20
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              btn_nickel,
    input  logic              btn_dime,
    input  logic              btn_fifty,
    input  logic              btn_coffee,
    input  logic              btn_coke,
    input  logic              btn_oolong,
    input  logic              btn_water,
    input  logic              btn_cancel,
    output vending_pkg::led_t leds,
    output logic [3:0]        digits,
    output vending_pkg::seg_t segments
);

    vending_pkg::coin_pulses_t coins;
    vending_pkg::product_sel_t select;
    vending_pkg::credit_t      payout_amount;
    vending_pkg::credit_t      payout_left;
    vending_pkg::credit_t      show_amount;
    logic                      cancel;
    logic                      payout_load;
    logic                      payout_done;

    // coin buttons
    button_pulse #(.DEBOUNCE_LEN(DEBOUNCE_LEN)) nickel_inst (
        .clk(clk), .rst(rst), .btn(btn_nickel), .press(coins.nickel)
    );
    button_pulse #(.DEBOUNCE_LEN(DEBOUNCE_LEN)) dime_inst (
        .clk(clk), .rst(rst), .btn(btn_dime), .press(coins.dime)
    );
    button_pulse #(.DEBOUNCE_LEN(DEBOUNCE_LEN)) fifty_inst (
        .clk(clk), .rst(rst), .btn(btn_fifty), .press(coins.fifty)
    );

    // product buttons
    button_pulse #(.DEBOUNCE_LEN(DEBOUNCE_LEN)) coffee_inst (
        .clk(clk), .rst(rst), .btn(btn_coffee), .press(select.coffee)
    );
    button_pulse #(.DEBOUNCE_LEN(DEBOUNCE_LEN)) coke_inst (
        .clk(clk), .rst(rst), .btn(btn_coke), .press(select.coke)
    );
    button_pulse #(.DEBOUNCE_LEN(DEBOUNCE_LEN)) oolong_inst (
        .clk(clk), .rst(rst), .btn(btn_oolong), .press(select.oolong)
    );
    button_pulse #(.DEBOUNCE_LEN(DEBOUNCE_LEN)) water_inst (
        .clk(clk), .rst(rst), .btn(btn_water), .press(select.water)
    );

    button_pulse #(.DEBOUNCE_LEN(DEBOUNCE_LEN)) cancel_inst (
        .clk(clk), .rst(rst), .btn(btn_cancel), .press(cancel)
    );

    vend_fsm vend_fsm_inst (
        .clk          (clk),
        .rst          (rst),
        .coins        (coins),
        .select       (select),
        .cancel       (cancel),
        .payout_left  (payout_left),
        .payout_done  (payout_done),
        .payout_load  (payout_load),
        .payout_amount(payout_amount),
        .show_amount  (show_amount),
        .leds         (leds)
    );

    change_dispenser #(.TICK_CYCLES(TICK_CYCLES)) change_dispenser_inst (
        .clk          (clk),
        .rst          (rst),
        .payout_load  (payout_load),
        .payout_amount(payout_amount),
        .payout_left  (payout_left),
        .payout_done  (payout_done)
    );

    seg_display #(.REFRESH_BITS(REFRESH_BITS)) seg_display_inst (
        .clk     (clk),
        .rst     (rst),
        .amount  (show_amount),
        .digits  (digits),
        .segments(segments)
    );

endmodule

/* verification/vending_checker.sv */
// vending FSM assertions
`timescale 1ns/1ps

module vending_checker (
    input logic                     clk,
    input logic                     rst,
    input vending_pkg::vend_state_t state,
    input vending_pkg::credit_t     credit,
    input vending_pkg::led_t        leds,
    input logic                     payout_load
);

    logic vending;
    int   failures = 0;

    assign vending = (state == vending_pkg::VEND_COFFEE) ||
                     (state == vending_pkg::VEND_COKE)   ||
                     (state == vending_pkg::VEND_OOLONG) ||
                     (state == vending_pkg::VEND_WATER);

    credit_limit: assert property (@(posedge clk) disable iff (rst)
        credit <= vending_pkg::CREDIT_MAX)
        else begin
            $error("credit above saturation value");
            failures++;
        end

    vend_leds_onehot: assert property (@(posedge clk) disable iff (rst)
        vending |-> $onehot(leds))
        else begin
            $error("leds not one-hot while vending");
            failures++;
        end

    refund_leds_off: assert property (@(posedge clk) disable iff (rst)
        (state == vending_pkg::REFUND) |-> (leds == '0))
        else begin
            $error("leds lit during refund");
            failures++;
        end

    // dispenser loads only from coin insertion
    load_in_insert: assert property (@(posedge clk) disable iff (rst)
        payout_load |-> (state == vending_pkg::INSERT))
        else begin
            $error("payout load outside coin insertion");
            failures++;
        end

    // a load always starts a vend or a refund
    load_leaves_insert: assert property (@(posedge clk) disable iff (rst)
        payout_load |=> (state != vending_pkg::INSERT))
        else begin
            $error("payout load without leaving coin insertion");
            failures++;
        end

endmodule

/* verification/tb_vending.sv */
// vending controller testbench
`timescale 1ns/1ps

module tb_vending;

    localparam int DEBOUNCE = 2;
    localparam int TICKS    = 16;
    localparam int REFRESH  = 4;
    localparam int SCAN     = 1 << REFRESH; // cycles in one refresh period
    localparam int HOLD     = 6;
    localparam int PRICE [4] = '{80, 30, 25, 20}; // coffee first
    // button masks, nickel on the top bit
    localparam logic [7:0] NICKEL = 8'h80;
    localparam logic [7:0] DIME   = 8'h40;
    localparam logic [7:0] FIFTY  = 8'h20;
    localparam logic [7:0] COFFEE = 8'h10;
    localparam logic [7:0] WATER  = 8'h02;
    localparam logic [7:0] CANCEL = 8'h01;

    logic              clk = 1'b0;
    logic              rst;
    logic [7:0]        buttons;
    vending_pkg::led_t leds;
    logic [3:0]        digits;
    vending_pkg::seg_t segments;
    logic [15:0]       lfsr;
    int                credit; // expected credit
    int                mismatches;
    int                timeouts;

    vending_top #(
        .DEBOUNCE_LEN(DEBOUNCE), .TICK_CYCLES(TICKS), .REFRESH_BITS(REFRESH)
    ) vending_top_inst (
        .clk(clk), .rst(rst), .btn_nickel(buttons[7]), .btn_dime(buttons[6]),
        .btn_fifty(buttons[5]), .btn_coffee(buttons[4]), .btn_coke(buttons[3]),
        .btn_oolong(buttons[2]), .btn_water(buttons[1]), .btn_cancel(buttons[0]),
        .leds(leds), .digits(digits), .segments(segments)
    );

    bind vend_fsm vending_checker vending_checker_inst (
        .clk(clk), .rst(rst), .state(state), .credit(credit),
        .leds(leds), .payout_load(payout_load)
    );

    always #2 clk = ~clk;

    // taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic int take_bits(input int n);
        int v;
        int i;
        v = 0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = (v << 1) | lfsr[0];
        end
        return v;
    endfunction

    // one press: next credit, led word, payout amount or -1
    function automatic void ref_model(input int cur, input logic [7:0] b, output int new_credit,
                                      output logic [3:0] led, output int payout);
        int i;
        new_credit = cur;
        payout     = -1;
        led        = 4'b0000;
        if (b[0]) begin
            payout     = cur; // whole credit back
            new_credit = 0;
        end else begin
            for (i = 0; i < 4; i++) begin
                if (payout < 0 && b[4-i] && cur >= PRICE[i]) begin
                    payout     = cur - PRICE[i];
                    led[3-i]   = 1'b1;
                    new_credit = 0;
                end
            end
        end
        if (payout < 0) begin
            new_credit += b[7] ? 5 : 0;
            new_credit += b[6] ? 10 : 0;
            new_credit += b[5] ? 50 : 0;
            if (new_credit > 100)
                new_credit = 100;
            for (i = 0; i < 4; i++)
                led[3-i] = (new_credit >= PRICE[i]);
        end
    endfunction

    task automatic check_leds(input logic [3:0] expected);
        if (leds !== expected) begin
            mismatches++;
            $display("MISMATCH at %0t: leds %b, expected %b", $time, leds, expected);
        end
    endtask

    // one refresh period, digits rebuilt by position
    task automatic check_display(input int expected);
        int pos_val [3];
        bit seen [3];
        int p;
        int d;
        int k;
        int value;
        int used;
        int scale;
        int want_used;
        bit bad;
        value = 0;
        used  = 0;
        bad   = 1'b0;
        for (p = 0; p < 3; p++)
            seen[p] = 1'b0;
        repeat (SCAN) begin
            @(negedge clk);
            case (digits)
                4'b1110: p = 0;
                4'b1101: p = 1;
                4'b1011: p = 2;
                default: p = -1;
            endcase
            d = -1;
            for (k = 0; k < 10; k++)
                if (segments == vending_pkg::SEG_DIGIT[k])
                    d = k;
            if (p < 0 || d < 0) begin
                bad = 1'b1;
            end else begin
                if (seen[p] && pos_val[p] != d)
                    bad = 1'b1;
                seen[p]    = 1'b1;
                pos_val[p] = d;
            end
        end
        scale = 1;
        for (p = 0; p < 3; p++) begin
            if (seen[p]) begin
                value += pos_val[p] * scale;
                used++;
            end
            scale *= 10;
        end
        want_used = (expected >= 100) ? 3 : (expected >= 10) ? 2 : 1;
        if (bad || value != expected || used != want_used) begin
            mismatches++;
            $display("MISMATCH at %0t: display %0d on %0d digits (garbled %0d), expected %0d on %0d",
                     $time, value, used, bad, expected, want_used);
        end
    endtask

    task automatic press(input logic [7:0] b);
        @(posedge clk);
        buttons <= b;
        repeat (HOLD) @(posedge clk);
        buttons <= '0;
        repeat (HOLD - 1) @(posedge clk);
    endtask

    task automatic press_and_check(input logic [7:0] b);
        int new_credit;
        logic [3:0] led;
        int payout;
        ref_model(credit, b, new_credit, led, payout);
        press(b);
        credit = new_credit;
        check_leds(led);
        check_display(credit);
    endtask

    // each payout value lasts one tick period from the load edge
    task automatic follow_payout(input int amount, input logic [3:0] led);
        int v;
        int n;
        repeat (DEBOUNCE + 2) @(posedge clk); // load edge
        for (v = amount; v > 0; v -= 5) begin
            check_display(v);
            check_leds(led);
            repeat (TICKS - SCAN) @(negedge clk); // rest of the tick period
        end
        check_display(0);
        n = 0;
        while (leds !== 4'b0000 && n < 64) begin
            @(negedge clk);
            n++;
        end
        if (leds !== 4'b0000) begin
            timeouts++;
            $display("timeout at %0t: machine did not return to coin insertion", $time);
        end
    endtask

    task automatic vend_and_check(input logic [7:0] b);
        int new_credit;
        logic [3:0] led;
        int payout;
        ref_model(credit, b, new_credit, led, payout);
        fork
            press(b);
            follow_payout(payout, led);
        join
        credit = new_credit;
    endtask

    initial begin
        int i;
        int pick;
        int assert_fails;
        rst        = 1'b1;
        buttons    = '0;
        lfsr       = 16'd2861;
        credit     = 0;
        mismatches = 0;
        timeouts   = 0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        check_leds(4'b0000);
        check_display(0);

        // random coins, saturating sum
        for (i = 0; i < 10; i++) begin
            pick = take_bits(2);
            case (pick)
                0:       press_and_check(NICKEL);
                2:       press_and_check(FIFTY);
                default: press_and_check(DIME);
            endcase
        end

        // every product in priority order
        for (i = 0; i < 4; i++) begin
            press_and_check(FIFTY);
            while (credit < PRICE[i])
                press_and_check(DIME);
            vend_and_check(COFFEE >> i);
        end

        // too little credit is ignored
        press_and_check(NICKEL);
        press_and_check(WATER);
        press_and_check(FIFTY);
        press_and_check(DIME);
        press_and_check(DIME);
        press_and_check(COFFEE);

        vend_and_check(CANCEL);

        // coffee wins over water
        press_and_check(FIFTY);
        press_and_check(FIFTY);
        vend_and_check(COFFEE | WATER);

        assert_fails = vending_top_inst.vend_fsm_inst.vending_checker_inst.failures;
        $display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
                 mismatches, timeouts, assert_fails);
        if (mismatches == 0 && timeouts == 0 && assert_fails == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* vlog.f */
rtl/vending_pkg.sv
rtl/button_pulse.sv
rtl/vend_fsm.sv
rtl/change_dispenser.sv
rtl/seg_display.sv
rtl/vending_top.sv
verification/vending_checker.sv
verification/tb_vending.sv

/* Makefile */
SIM      ?= verilator
TOP      ?= tb_vending
FILELIST ?= vlog.f
OBJ_DIR  ?= obj_dir
LOG      ?= sim.log
SIMFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with $(SIM), run $(TOP), check $(LOG) for the pass line"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"

test:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "=== PASS ===" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
